/* design/cart_pkg.sv */
`default_nettype none

package cart_pkg;

	// ======================================================================
	// Map kinds and slot selection
	// ======================================================================

	// The encoding is the map_type input value and also the slot index.
	typedef enum logic [1:0] {
		MAP_LOROM   = 2'd0,
		MAP_HIROM   = 2'd1,
		MAP_EXHIROM = 2'd2
	} map_kind_t;

	localparam int N_MAPS = 3;

	typedef logic [N_MAPS-1:0] map_sel_t; // One-hot, bit i selects slot i.

	// ======================================================================
	// Bus and memory widths
	// ======================================================================

	typedef logic [23:0] cpu_addr_t;   // Bank in bits 23:16.
	typedef logic [23:0] rom_addr_t;
	typedef logic [19:0] bsram_addr_t;
	typedef logic [7:0]  data_t;

	// Read that hits no cartridge memory.
	localparam data_t OPEN_BUS = 8'hFF;

	// Work RAM banks stay inside the console.
	localparam logic [7:0] WRAM_BANK_LO = 8'h7E;
	localparam logic [7:0] WRAM_BANK_HI = 8'h7F;

endpackage

`default_nettype wire

/* design/map_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded request of one mapper slot.
interface map_req_if
	import cart_pkg::*;
();

	logic        rom_hit;
	rom_addr_t   rom_addr;
	logic        bsram_hit;
	bsram_addr_t bsram_addr;

	modport slot (
		output rom_hit,
		output rom_addr,
		output bsram_hit,
		output bsram_addr
	);

	modport mux (
		input rom_hit,
		input rom_addr,
		input bsram_hit,
		input bsram_addr
	);

endinterface

`default_nettype wire

/* design/map_select.sv */
`timescale 1ns/1ps
`default_nettype none

module map_select
	import cart_pkg::*;
(
	input  logic       mclk,
	input  logic       reset,
	input  logic [1:0] map_type,
	output map_sel_t   map_active
);

	map_sel_t sel_d;

	// Unknown map types fall back to the first mapper.
	always_comb begin
		sel_d = '0;
		if (map_type < N_MAPS)
			sel_d[map_type] = 1'b1;
		else
			sel_d[MAP_LOROM] = 1'b1;
	end

	always_ff @(posedge mclk) begin
		if (reset)
			map_active <= map_sel_t'(1); // Slot 0.
		else
			map_active <= sel_d;
	end

	// Exactly one slot drives the cartridge pins.
	a_onehot: assert property (@(posedge mclk) disable iff (reset)
		$onehot(map_active));

endmodule

`default_nettype wire

/* design/cart_map.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_map
	import cart_pkg::*;
#(
	parameter map_kind_t MAP_KIND = MAP_LOROM
) (
	input  cpu_addr_t   ca,
	input  rom_addr_t   rom_mask,
	input  bsram_addr_t ram_mask,
	map_req_if.slot     req
);

	logic [7:0]  bank;
	logic        wram_bank;
	logic        rom_region;
	logic        bsram_win;
	rom_addr_t   rom_raw;
	bsram_addr_t ram_raw;

	assign bank      = ca[23:16];
	assign wram_bank = (bank == WRAM_BANK_LO) || (bank == WRAM_BANK_HI);

	// Upper half of any bank, or the whole of banks 40-7D and C0-FF.
	assign rom_region = !wram_bank && (ca[15] || ca[22]);

	// ======================================================================
	// Address decode per map kind
	// ======================================================================

	always_comb begin
		if (MAP_KIND == MAP_LOROM) begin
			// 32 KB pages, save RAM in the low half of banks 70-7D.
			bsram_win = (bank >= 8'h70) && (bank <= 8'h7D) && !ca[15];
			rom_raw   = {2'b00, ca[22:16], ca[14:0]};
			ram_raw   = {1'b0, ca[19:16], ca[14:0]};
		end else begin
			// 8 KB save RAM window at 6000-7FFF of banks 20-3F and A0-BF.
			bsram_win = !ca[22] && ca[21] && (ca[15:13] == 3'b011);
			rom_raw   = {2'b00, ca[21:0]};
			ram_raw   = {2'b00, ca[20:16], ca[12:0]};
			if (MAP_KIND == MAP_EXHIROM)
				rom_raw[22] = ~ca[23]; // Banks 40-7D map above 4 MB.
		end
	end

	// Save RAM wins where both windows overlap.
	assign req.bsram_hit  = bsram_win;
	assign req.rom_hit    = rom_region && !bsram_win;
	assign req.rom_addr   = rom_raw & rom_mask;
	assign req.bsram_addr = ram_raw & ram_mask;

	// The save RAM window never opens in the work RAM banks.
	always_comb begin
		a_wram: assert final (!(wram_bank && req.bsram_hit))
			else $error("cart_map: BSRAM hit in a work RAM bank");
	end

endmodule

`default_nettype wire

/* design/map_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module map_mux
	import cart_pkg::*;
(
	input  logic        mclk,
	input  logic        reset,
	input  map_sel_t    map_active,
	map_req_if.mux      req [N_MAPS],
	input  logic        cpurd_n,
	input  logic        cpuwr_n,
	input  data_t       cpu_do,
	input  logic [15:0] rom_q,
	input  data_t       bsram_q,
	output rom_addr_t   rom_addr,
	output logic        rom_ce_n,
	output logic        rom_oe_n,
	output bsram_addr_t bsram_addr,
	output data_t       bsram_d,
	output logic        bsram_ce_n,
	output logic        bsram_oe_n,
	output logic        bsram_we_n,
	output data_t       cpu_di
);

	logic [N_MAPS-1:0] rom_hit_s;
	logic [N_MAPS-1:0] bsram_hit_s;
	rom_addr_t         rom_addr_s [N_MAPS];
	bsram_addr_t       bsram_addr_s [N_MAPS];
	logic              sel_rom_hit;
	logic              sel_bsram_hit;
	rom_addr_t         sel_rom_addr;
	bsram_addr_t       sel_bsram_addr;
	logic              rd;
	logic              wr;
	logic              src_rom;
	logic              src_bsram;

	for (genvar i = 0; i < N_MAPS; i++) begin : g_slot
		assign rom_hit_s[i]    = req[i].rom_hit;
		assign bsram_hit_s[i]  = req[i].bsram_hit;
		assign rom_addr_s[i]   = req[i].rom_addr;
		assign bsram_addr_s[i] = req[i].bsram_addr;
	end

	// AND-OR select, map_active is one-hot.
	always_comb begin
		sel_rom_hit    = 1'b0;
		sel_bsram_hit  = 1'b0;
		sel_rom_addr   = '0;
		sel_bsram_addr = '0;
		for (int i = 0; i < N_MAPS; i++) begin
			if (map_active[i]) begin
				sel_rom_hit    = sel_rom_hit | rom_hit_s[i];
				sel_bsram_hit  = sel_bsram_hit | bsram_hit_s[i];
				sel_rom_addr   = sel_rom_addr | rom_addr_s[i];
				sel_bsram_addr = sel_bsram_addr | bsram_addr_s[i];
			end
		end
	end

	assign rd = !cpurd_n;
	assign wr = !cpuwr_n;

	// ======================================================================
	// Registered cartridge pins
	// ======================================================================

	always_ff @(posedge mclk) begin
		if (reset) begin
			rom_ce_n   <= 1'b1;
			rom_oe_n   <= 1'b1;
			bsram_ce_n <= 1'b1;
			bsram_oe_n <= 1'b1;
			bsram_we_n <= 1'b1;
			src_rom    <= 1'b0;
			src_bsram  <= 1'b0;
		end else begin
			rom_ce_n   <= !(rd && sel_rom_hit); // ROM is read only.
			rom_oe_n   <= !(rd && sel_rom_hit);
			bsram_ce_n <= !((rd || wr) && sel_bsram_hit);
			bsram_oe_n <= !(rd && sel_bsram_hit);
			bsram_we_n <= !(wr && sel_bsram_hit);
			src_rom    <= rd && sel_rom_hit;
			src_bsram  <= rd && sel_bsram_hit;
		end
	end

	always_ff @(posedge mclk) begin
		rom_addr   <= sel_rom_addr;
		bsram_addr <= sel_bsram_addr;
		bsram_d    <= cpu_do;
	end

	// Data of the previous read, open bus otherwise.
	assign cpu_di = src_bsram ? bsram_q : (src_rom ? rom_q[7:0] : OPEN_BUS);

	a_bsram_rw: assert property (@(posedge mclk) disable iff (reset)
		!(!bsram_we_n && !bsram_oe_n));

endmodule

`default_nettype wire

/* design/cart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_top
	import cart_pkg::*;
(
	input  logic        mclk,
	input  logic        reset,

	input  logic [1:0]  map_type,
	input  rom_addr_t   rom_mask,
	input  bsram_addr_t ram_mask,

	input  cpu_addr_t   ca,
	input  logic        cpurd_n,
	input  logic        cpuwr_n,
	input  data_t       cpu_do,
	output data_t       cpu_di,

	output rom_addr_t   rom_addr,
	input  logic [15:0] rom_q,
	output logic        rom_ce_n,
	output logic        rom_oe_n,

	output bsram_addr_t bsram_addr,
	output data_t       bsram_d,
	input  data_t       bsram_q,
	output logic        bsram_ce_n,
	output logic        bsram_oe_n,
	output logic        bsram_we_n
);

	map_sel_t map_active;

	map_req_if req_if [N_MAPS] ();

	map_select i_map_select (
		.mclk       (mclk),
		.reset      (reset),
		.map_type   (map_type),
		.map_active (map_active)
	);

	// ======================================================================
	// One mapper slot per map kind
	// ======================================================================

	for (genvar i = 0; i < N_MAPS; i++) begin : g_map
		cart_map #(
			.MAP_KIND (map_kind_t'(i))
		) i_cart_map (
			.ca       (ca),
			.rom_mask (rom_mask),
			.ram_mask (ram_mask),
			.req      (req_if[i])
		);
	end

	map_mux i_map_mux (
		.mclk       (mclk),
		.reset      (reset),
		.map_active (map_active),
		.req        (req_if),
		.cpurd_n    (cpurd_n),
		.cpuwr_n    (cpuwr_n),
		.cpu_do     (cpu_do),
		.rom_q      (rom_q),
		.bsram_q    (bsram_q),
		.rom_addr   (rom_addr),
		.rom_ce_n   (rom_ce_n),
		.rom_oe_n   (rom_oe_n),
		.bsram_addr (bsram_addr),
		.bsram_d    (bsram_d),
		.bsram_ce_n (bsram_ce_n),
		.bsram_oe_n (bsram_oe_n),
		.bsram_we_n (bsram_we_n),
		.cpu_di     (cpu_di)
	);

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and a reset held for the first cycles.
module tb_clock #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic mclk,
	output logic reset
);

	initial begin
		mclk = 1'b0;
		forever #(PERIOD_NS / 2) mclk = ~mclk;
	end

	initial begin
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge mclk);
		reset <= 1'b0; // Released on an edge, like the stimulus.
	end

endmodule

`default_nettype wire

/* tb/tb_cart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cart_top
	import cart_pkg::*;
();

	localparam int N_ACCESSES     = 1200;
	localparam int MAP_PERIOD     = 200;
	localparam int TIMEOUT_CYCLES = N_ACCESSES + 100;

	logic        mclk, reset;
	logic [1:0]  map_type;
	rom_addr_t   rom_mask, rom_addr;
	bsram_addr_t ram_mask, bsram_addr;
	cpu_addr_t   ca;
	logic        cpurd_n, cpuwr_n;
	data_t       cpu_do, cpu_di, bsram_d, bsram_q;
	logic [15:0] rom_q;
	logic        rom_ce_n, rom_oe_n, bsram_ce_n, bsram_oe_n, bsram_we_n;

	integer seed = 32'h3a6aefce;
	int     cycles, checks, mismatches;

	// Model of the cycle that the DUT has just registered.
	map_kind_t   model_kind = MAP_LOROM;
	logic        exp_valid = 1'b0;
	logic [4:0]  exp_ctrl; // rom_ce_n rom_oe_n bsram_ce_n bsram_oe_n bsram_we_n.
	logic        exp_rom_rd, exp_bsram_rd, exp_bsram_wr;
	rom_addr_t   exp_rom_addr;
	bsram_addr_t exp_bsram_addr;
	data_t       exp_bsram_d;

	tb_clock i_clock (.mclk(mclk), .reset(reset));

	cart_top i_dut (.*);

	// ======================================================================
	// Reference model of the address maps
	// ======================================================================

	function automatic logic bsram_hit_of(input map_kind_t k, input cpu_addr_t a);
		if (k == MAP_LOROM)
			return a[23:16] >= 8'h70 && a[23:16] <= 8'h7D && !a[15];
		return !a[22] && a[21] && a[15:13] == 3'b011;
	endfunction

	function automatic logic rom_hit_of(input map_kind_t k, input cpu_addr_t a);
		logic wram;
		wram = a[23:16] == WRAM_BANK_LO || a[23:16] == WRAM_BANK_HI;
		return !wram && (a[15] || a[22]) && !bsram_hit_of(k, a); // Save RAM first.
	endfunction

	function automatic rom_addr_t rom_addr_of(input map_kind_t k, input cpu_addr_t a);
		if (k == MAP_LOROM)
			return rom_addr_t'({a[22:16], a[14:0]});
		if (k == MAP_HIROM)
			return rom_addr_t'(a[21:0]);
		return rom_addr_t'({~a[23], a[21:0]});
	endfunction

	function automatic bsram_addr_t bsram_addr_of(input map_kind_t k, input cpu_addr_t a);
		if (k == MAP_LOROM)
			return bsram_addr_t'({a[19:16], a[14:0]});
		return bsram_addr_t'({a[20:16], a[12:0]});
	endfunction

	task automatic check_rom(input rom_addr_t got, input rom_addr_t exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: rom_addr got %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_bsram(input bsram_addr_t got, input bsram_addr_t exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: bsram_addr got %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ctrl(input logic [4:0] got, input logic [4:0] exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: controls got %b, expected %b", $time, got, exp);
		end
	endtask

	// Predict what the DUT registers at this edge from the inputs it samples now.
	always @(posedge mclk) begin : model_step
		logic rd;
		logic wr;
		rd = !cpurd_n && !reset;
		wr = !cpuwr_n && !reset;
		exp_rom_rd     = rd && rom_hit_of(model_kind, ca);
		exp_bsram_rd   = rd && bsram_hit_of(model_kind, ca);
		exp_bsram_wr   = wr && bsram_hit_of(model_kind, ca);
		exp_ctrl       = {!exp_rom_rd, !exp_rom_rd, !(exp_bsram_rd || exp_bsram_wr),
			!exp_bsram_rd, !exp_bsram_wr};
		exp_rom_addr   = rom_addr_of(model_kind, ca) & rom_mask;
		exp_bsram_addr = bsram_addr_of(model_kind, ca) & ram_mask;
		exp_bsram_d    = cpu_do;
		exp_valid      = 1'b1;
		if (reset || map_type == 2'd3)
			model_kind = MAP_LOROM; // Map type 3 falls back to LoROM.
		else
			model_kind = map_kind_t'(map_type);
	end

	always @(negedge mclk) begin
		if (exp_valid) begin
			check_ctrl({rom_ce_n, rom_oe_n, bsram_ce_n, bsram_oe_n, bsram_we_n}, exp_ctrl);
			if (exp_bsram_rd)
				check_data(cpu_di, bsram_q, "cpu_di");
			else if (exp_rom_rd)
				check_data(cpu_di, rom_q[7:0], "cpu_di");
			else
				check_data(cpu_di, OPEN_BUS, "cpu_di");
			if (exp_rom_rd)
				check_rom(rom_addr, exp_rom_addr);
			if (exp_bsram_rd || exp_bsram_wr)
				check_bsram(bsram_addr, exp_bsram_addr);
			if (exp_bsram_wr)
				check_data(bsram_d, exp_bsram_d, "bsram_d");
		end
	end

	always @(posedge mclk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the stimulus did not finish", cycles);
			$display("Checks %0d, mismatches %0d", checks, mismatches);
			$display("Simulation failed");
			$finish;
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	// One cycle of random bus traffic. Idle cycles keep both strobes high.
	task automatic drive_cycle(input logic idle);
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] t;
		logic [7:0]  bank;
		logic [15:0] offs;
		r = $random(seed);
		s = $random(seed);
		t = $random(seed);
		case (r[3:0])
			4'd0, 4'd1:             bank = 8'h00;
			4'd2, 4'd3, 4'd4, 4'd5: bank = {3'b001, r[8:4]}; // Banks 20 to 3F.
			4'd6:                   bank = 8'h40;
			4'd7, 4'd8, 4'd9:       bank = {4'h7, r[7:4]};
			4'd10:                  bank = 8'h80;
			4'd11:                  bank = 8'hC0;
			default:                bank = r[31:24];
		endcase
		offs = s[15:0];
		if (s[16])
			offs[15:13] = 3'b011; // HiROM save RAM window.
		@(posedge mclk);
		ca      <= {bank, offs};
		cpurd_n <= idle || !r[9];
		cpuwr_n <= idle || r[9] || r[11:10] == 2'b00;
		cpu_do  <= s[24:17];
		rom_q   <= r[31:16];
		bsram_q <= s[31:24];
		if (t[4:0] == 5'd0) begin
			rom_mask <= 24'hFFFFFF >> t[7:5];
			ram_mask <= 20'hFFFFF >> t[10:8];
		end
	endtask

	initial begin
		map_type <= 2'd0;
		rom_mask <= '1;
		ram_mask <= '1;
		ca       <= '0;
		cpurd_n  <= 1'b1;
		cpuwr_n  <= 1'b1;
		cpu_do   <= '0;
		rom_q    <= '0;
		bsram_q  <= '0;
		@(posedge mclk);
		while (reset)
			@(posedge mclk);
		for (int i = 0; i < N_ACCESSES; i++) begin
			// Map types 0 to 3 in turn, then random ones.
			if (i % MAP_PERIOD == 0) begin
				drive_cycle(1'b1);
				map_type <= (i < 4 * MAP_PERIOD) ? 2'(i / MAP_PERIOD) : 2'($random(seed));
				drive_cycle(1'b1);
			end
			drive_cycle(1'b0);
		end
		drive_cycle(1'b1);
		drive_cycle(1'b1);
		@(posedge mclk);
		$display("Checks %0d, mismatches %0d", checks, mismatches);
		if (mismatches == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
design/cart_pkg.sv
design/map_req_if.sv
design/map_select.sv
design/cart_map.sv
design/map_mux.sv
design/cart_top.sv
tb/tb_clock.sv
tb/tb_cart_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cart_top testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cart_top -f filelist.f

status=0
./obj_dir/Vtb_cart_top > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
	echo "Run failed, see sim.log"
	exit 1
fi
echo "Run passed"
